// ==== logic/mbu_cfg.svh ====
/*
  Unit addresses and sizes of the Memory Bank Unit
  Addresses are the 5-bit read and write unit codes of the control unit
  Widths are fixed by the register file layout {ctx, index}
*/

`ifndef MBU_CFG_SVH
`define MBU_CFG_SVH

// Read and write unit addresses
`define MBU_ADDR_MBN    5'h1B    // Indexed bank register
`define MBU_ADDR_MBP    5'h1C    // Bank register 0
`define MBU_ADDR_CTX0   5'h1D    // Context register
`define MBU_ADDR_CTX1   5'h1E    // Context register alias

// Write-AR strobes occupy waddr 0x04..0x07
`define MBU_WAR_GROUP   3'b001

// Widths
`define MBU_DATA_W      8        // Bank register and bus width
`define MBU_IDX_W       3        // Eight banks per context
`define MBU_CTX_W       8        // 256 contexts
`define MBU_RAM_AW      11       // CTX_W + IDX_W

// Returned while the unit is still disabled
`define MBU_PON_ROM     8'h80    // Front panel switch high
`define MBU_PON_RAM     8'h00    // Front panel switch low

`endif

// ==== logic/mbu_pkg.sv ====
/*
  Shared types of the Memory Bank Unit
  Widths come from the configuration header
  Both structs are plain levels with no handshake
*/

`include "mbu_cfg.svh"

package mbu_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Decoded unit strobes
   ////////////////////////////////////////////////////////////////////////////

   // Read flags are pure address compares
   // Write flags are already qualified by wen
   typedef struct packed {
      logic rd_mbn;    // Indexed bank onto the bus
      logic rd_mbp;    // Bank 0 onto the bus
      logic rd_ctx;    // Context register onto the bus
      logic wr_mbn;    // Bus into indexed bank
      logic wr_mbp;    // Bus into bank 0
      logic wr_ctx;    // Bus into context register
      logic wr_ar;     // One of the four write-AR strobes
   } mbu_strobes_t;

   ////////////////////////////////////////////////////////////////////////////
   // Register file write request
   ////////////////////////////////////////////////////////////////////////////

   // Taken by the RAM at the next rising clock edge
   typedef struct packed {
      logic                   en;      // Write this cycle
      logic [`MBU_RAM_AW-1:0] addr;    // {ctx, bank index}
      logic [`MBU_DATA_W-1:0] data;    // Straight from the bus
   } mbu_ram_wr_t;

endpackage

// ==== logic/mbu_decoder.sv ====
/*
  Unit address decoder of the MBU
  Purely combinational
  Write strobes are only live while wen is high
  war is a copy of the write-AR strobe for the external address register
*/

`timescale 1ns/1ps
`include "mbu_cfg.svh"

module mbu_decoder (
   input  logic [4:0]            raddr,      // Read unit
   input  logic [4:0]            waddr,      // Write unit
   input  logic                  wen,        // Write phase
   output mbu_pkg::mbu_strobes_t strobes,
   output logic                  war
);

   logic wsel_mbn;    // waddr hits MBn
   logic wsel_mbp;    // waddr hits MBP
   logic wsel_ctx;    // waddr hits either CTX alias
   logic wsel_ar;     // waddr inside the write-AR group

   // Read side
   // Both CTX aliases map to the same register
   assign strobes.rd_mbn = (raddr == `MBU_ADDR_MBN);
   assign strobes.rd_mbp = (raddr == `MBU_ADDR_MBP);
   assign strobes.rd_ctx = (raddr == `MBU_ADDR_CTX0) ||
                           (raddr == `MBU_ADDR_CTX1);

   // Write side address compares
   assign wsel_mbn = (waddr == `MBU_ADDR_MBN);
   assign wsel_mbp = (waddr == `MBU_ADDR_MBP);
   assign wsel_ctx = (waddr == `MBU_ADDR_CTX0) ||
                     (waddr == `MBU_ADDR_CTX1);

   // Four AR strobes differ only in waddr[1:0]
   assign wsel_ar  = (waddr[4:2] == `MBU_WAR_GROUP);

   // Qualify with the write phase
   assign strobes.wr_mbn = wsel_mbn && wen;
   assign strobes.wr_mbp = wsel_mbp && wen;
   assign strobes.wr_ctx = wsel_ctx && wen;
   assign strobes.wr_ar  = wsel_ar  && wen;

   assign war = strobes.wr_ar;    // To the AR outside the MBU

endmodule

// ==== logic/mbu_control.sv ====
/*
  MBU control with the context register and the enable flag
  Disabled after reset so bank reads and aext give the power-on value
  The first MBn write enables the unit and only reset disables it again
  Bank writes land in the register file even while disabled
  aext is zero outside write-AR cycles
*/

`timescale 1ns/1ps
`include "mbu_cfg.svh"

module mbu_control (
   input  logic                   clk4,
   input  logic                   arst_n,
   input  mbu_pkg::mbu_strobes_t  strobes,
   input  logic [`MBU_DATA_W-1:0] ibus_in,
   input  logic [1:0]             waddr_lo,     // AR strobe number
   input  logic [`MBU_IDX_W-1:0]  ir,           // Bank index from the instruction
   input  logic                   ir_idx,       // Use ir for aext
   input  logic                   fpram_rom,    // Front panel RAM/ROM switch
   input  logic [`MBU_DATA_W-1:0] rd_data,
   input  logic [`MBU_DATA_W-1:0] ar_data,
   output mbu_pkg::mbu_ram_wr_t   ram_wr,
   output logic [`MBU_RAM_AW-1:0] rd_addr,
   output logic [`MBU_RAM_AW-1:0] ar_addr,
   output logic [`MBU_DATA_W-1:0] ibus_out,
   output logic                   ibus_oe,
   output logic [`MBU_DATA_W-1:0] aext
);

   logic [`MBU_CTX_W-1:0]  ctx;         // Current context
   logic                   mbu_en;      // Low until the first MBn write
   logic [`MBU_DATA_W-1:0] pon_val;     // Power-on bank value
   logic [`MBU_IDX_W-1:0]  rd_idx;      // Bus read bank
   logic [`MBU_IDX_W-1:0]  wr_idx;      // Bus write bank
   logic [`MBU_IDX_W-1:0]  ar_idx;      // Address extension bank
   logic [`MBU_DATA_W-1:0] bank_val;    // Bank read after the enable check

   ////////////////////////////////////////////////////////////////////////////
   // Context register and enable flag
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk4 or negedge arst_n) begin
      if (!arst_n) begin
         ctx    <= '0;
         mbu_en <= 1'b0;
      end else begin
         if (strobes.wr_ctx) begin
            ctx <= ibus_in;
         end
         if (strobes.wr_mbn) begin
            mbu_en <= 1'b1;    // Sticky
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Bank index selection
   ////////////////////////////////////////////////////////////////////////////

   // MBP is always bank 0
   assign rd_idx = strobes.rd_mbn ? ir : '0;
   assign wr_idx = strobes.wr_mbn ? ir : '0;

   // Strobe number picks the bank unless the CU asks for ir
   assign ar_idx = ir_idx ? ir : {{(`MBU_IDX_W-2){1'b0}}, waddr_lo};

   // Context is the high part of every RAM address
   assign rd_addr = {ctx, rd_idx};
   assign ar_addr = {ctx, ar_idx};

   always_comb begin
      ram_wr.en   = strobes.wr_mbn || strobes.wr_mbp;
      ram_wr.addr = {ctx, wr_idx};
      ram_wr.data = ibus_in;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Output multiplexing
   ////////////////////////////////////////////////////////////////////////////

   assign pon_val  = fpram_rom ? `MBU_PON_ROM : `MBU_PON_RAM;
   assign bank_val = mbu_en ? rd_data : pon_val;

   assign ibus_oe = strobes.rd_mbn || strobes.rd_mbp || strobes.rd_ctx;

   always_comb begin
      if (strobes.rd_ctx) begin
         ibus_out = ctx;
      end else if (strobes.rd_mbn || strobes.rd_mbp) begin
         ibus_out = bank_val;
      end else begin
         ibus_out = '0;    // Not driving
      end
   end

   // Extension only during write-AR
   always_comb begin
      if (strobes.wr_ar) begin
         aext = mbu_en ? ar_data : pon_val;
      end else begin
         aext = '0;    // Pulled low when idle
      end
   end

endmodule

// ==== logic/mbu_bank_ram.sv ====
/*
  Bank register file of the MBU
  2048 bytes as 256 contexts of eight banks
  One write port taken at the rising edge and two asynchronous read ports
  Contents are undefined after power-up
*/

`timescale 1ns/1ps
`include "mbu_cfg.svh"

module mbu_bank_ram (
   input  logic                   clk4,
   input  mbu_pkg::mbu_ram_wr_t   ram_wr,     // Write request from control
   input  logic [`MBU_RAM_AW-1:0] rd_addr,    // Bus read port
   input  logic [`MBU_RAM_AW-1:0] ar_addr,    // Address extension port
   output logic [`MBU_DATA_W-1:0] rd_data,
   output logic [`MBU_DATA_W-1:0] ar_data
);

   localparam int DEPTH = 1 << `MBU_RAM_AW;    // 2048 entries

   // Indexed as {ctx, bank}
   logic [`MBU_DATA_W-1:0] mem [DEPTH];

   ////////////////////////////////////////////////////////////////////////////
   // Write port
   ////////////////////////////////////////////////////////////////////////////

   // Same edge as the context register so a write to MBn uses the old ctx
   always_ff @(posedge clk4) begin
      if (ram_wr.en) begin
         mem[ram_wr.addr] <= ram_wr.data;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Read ports
   ////////////////////////////////////////////////////////////////////////////

   // Both combinational
   // A read in the write cycle still returns the old byte
   assign rd_data = mem[rd_addr];
   assign ar_data = mem[ar_addr];    // Only looked at in write-AR cycles

endmodule

// ==== logic/mbu.sv ====
/*
  Memory Bank Unit top level
  Tri-state buses are split into in and out ports with an output enable
  Everything runs on the rising edge of clk4 with wen as the write phase
  aext is only meaningful while war is high
*/

`timescale 1ns/1ps
`include "mbu_cfg.svh"

module mbu (
   input  logic                   clk4,
   input  logic                   arst_n,
   input  logic [4:0]             raddr,        // Read unit address
   input  logic [4:0]             waddr,        // Write unit address
   input  logic                   wen,          // Write phase
   input  logic [`MBU_DATA_W-1:0] ibus_in,      // Low byte of the internal bus
   input  logic [`MBU_IDX_W-1:0]  ir,           // ir[2:0]
   input  logic                   ir_idx,       // Bank from ir during write-AR
   input  logic                   fpram_rom,    // Front panel switch
   output logic [`MBU_DATA_W-1:0] ibus_out,
   output logic                   ibus_oe,
   output logic [`MBU_DATA_W-1:0] aext,         // Address extension
   output logic                   war           // Write-AR for the AR
);

   import mbu_pkg::*;

   mbu_strobes_t           strobes;
   mbu_ram_wr_t            ram_wr;
   logic [`MBU_RAM_AW-1:0] rd_addr;
   logic [`MBU_RAM_AW-1:0] ar_addr;
   logic [`MBU_DATA_W-1:0] rd_data;
   logic [`MBU_DATA_W-1:0] ar_data;

   ////////////////////////////////////////////////////////////////////////////
   // Decode, control and register file
   ////////////////////////////////////////////////////////////////////////////

   mbu_decoder decoder_i (
      .raddr   (raddr),
      .waddr   (waddr),
      .wen     (wen),
      .strobes (strobes),
      .war     (war)
   );

   mbu_control control_i (
      .clk4      (clk4),
      .arst_n    (arst_n),
      .strobes   (strobes),
      .ibus_in   (ibus_in),
      .waddr_lo  (waddr[1:0]),    // Strobe number within the AR group
      .ir        (ir),
      .ir_idx    (ir_idx),
      .fpram_rom (fpram_rom),
      .rd_data   (rd_data),
      .ar_data   (ar_data),
      .ram_wr    (ram_wr),
      .rd_addr   (rd_addr),
      .ar_addr   (ar_addr),
      .ibus_out  (ibus_out),
      .ibus_oe   (ibus_oe),
      .aext      (aext)
   );

   mbu_bank_ram bank_ram_i (
      .clk4    (clk4),
      .ram_wr  (ram_wr),
      .rd_addr (rd_addr),
      .ar_addr (ar_addr),
      .rd_data (rd_data),
      .ar_data (ar_data)
   );

endmodule

// ==== verification/mbu_tb.sv ====
/*
  Self-checking testbench of the Memory Bank Unit
  Inputs change 1 ns after the rising edge and outputs are checked 1 ns before it
  Only the four filled contexts are ever selected once the unit is enabled
  ibus_out is compared while ibus_oe is high and aext while war is high
*/

`timescale 1ns/1ps
`include "mbu_cfg.svh"

module mbu_tb;

   localparam int CLK_PERIOD   = 10;
   localparam int RST_CYCLES   = 10;
   localparam int DIR_CYCLES   = 250;     // Upper bound of the directed phases
   localparam int RAND_CYCLES  = 2000;
   localparam int TEST_CYCLES  = DIR_CYCLES + RAND_CYCLES;
   localparam int WATCHDOG_NS  = (RST_CYCLES + TEST_CYCLES) * CLK_PERIOD * 2;
   localparam int NUM_CTX      = 4;       // Picked with a two-bit index
   localparam int unsigned SEED = 32'ha985_ce44;

   // One cycle of DUT inputs
   typedef struct packed {
      logic [4:0] raddr;
      logic [4:0] waddr;
      logic       wen;
      logic [7:0] ibus_in;
      logic [2:0] ir;
      logic       ir_idx;
      logic       fpram_rom;
   } stim_t;

   // Expected DUT outputs
   typedef struct packed {
      logic [7:0] ibus_out;
      logic       ibus_oe;
      logic [7:0] aext;
      logic       war;
   } resp_t;

   logic       clk4;
   logic       arst_n;
   logic [4:0] raddr;
   logic [4:0] waddr;
   logic       wen;
   logic [7:0] ibus_in;
   logic [2:0] ir;
   logic       ir_idx;
   logic       fpram_rom;
   logic [7:0] ibus_out;
   logic       ibus_oe;
   logic [7:0] aext;
   logic       war;

   // Reference model state
   logic [7:0]  shadow [2048];     // {ctx, bank}
   bit          written [2048];    // Bank has been stored at least once
   logic [7:0]  m_ctx;
   logic        m_en;
   logic        switch_val;        // Front panel switch for the next cycles
   logic [7:0]  ctx_list [NUM_CTX] = '{8'h00, 8'h01, 8'h7E, 8'hFF};
   int          checks;
   int          errors;
   int unsigned seed_val;

   mbu dut_i (
      .clk4      (clk4),
      .arst_n    (arst_n),
      .raddr     (raddr),
      .waddr     (waddr),
      .wen       (wen),
      .ibus_in   (ibus_in),
      .ir        (ir),
      .ir_idx    (ir_idx),
      .fpram_rom (fpram_rom),
      .ibus_out  (ibus_out),
      .ibus_oe   (ibus_oe),
      .aext      (aext),
      .war       (war)
   );

   always #(CLK_PERIOD / 2) clk4 = ~clk4;

   ////////////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////////////

   function automatic resp_t expected_outputs();
      resp_t      e;
      logic [7:0] pon;
      logic [2:0] rd_idx;
      logic [2:0] ar_idx;
      e      = '0;
      pon    = fpram_rom ? `MBU_PON_ROM : `MBU_PON_RAM;
      rd_idx = (raddr == `MBU_ADDR_MBN) ? ir : 3'd0;    // MBP is bank 0
      ar_idx = ir_idx ? ir : {1'b0, waddr[1:0]};
      if (raddr == `MBU_ADDR_CTX0 || raddr == `MBU_ADDR_CTX1) begin
         e.ibus_oe  = 1'b1;
         e.ibus_out = m_ctx;
      end else if (raddr == `MBU_ADDR_MBN || raddr == `MBU_ADDR_MBP) begin
         e.ibus_oe  = 1'b1;
         e.ibus_out = m_en ? shadow[{m_ctx, rd_idx}] : pon;
      end
      e.war = wen && (waddr[4:2] == `MBU_WAR_GROUP);
      if (e.war) begin
         e.aext = m_en ? shadow[{m_ctx, ar_idx}] : pon;
      end
      return e;
   endfunction

   // Catches stimulus that would look at a byte the model never saw
   function automatic bit unwritten_read();
      bit         hit;
      logic [2:0] ar_idx;
      hit    = 1'b0;
      ar_idx = ir_idx ? ir : {1'b0, waddr[1:0]};
      if (m_en) begin
         if (raddr == `MBU_ADDR_MBN && !written[{m_ctx, ir}]) begin
            hit = 1'b1;
         end
         if (raddr == `MBU_ADDR_MBP && !written[{m_ctx, 3'd0}]) begin
            hit = 1'b1;
         end
         if (wen && waddr[4:2] == `MBU_WAR_GROUP && !written[{m_ctx, ar_idx}]) begin
            hit = 1'b1;
         end
      end
      return hit;
   endfunction

   // State change at the coming edge
   task automatic update_model();
      if (wen && waddr == `MBU_ADDR_MBN) begin
         shadow[{m_ctx, ir}]  = ibus_in;
         written[{m_ctx, ir}] = 1'b1;
         m_en                 = 1'b1;    // First MBn write enables
      end
      if (wen && waddr == `MBU_ADDR_MBP) begin
         shadow[{m_ctx, 3'd0}]  = ibus_in;
         written[{m_ctx, 3'd0}] = 1'b1;
      end
      // Bank write above still used the old context
      if (wen && (waddr == `MBU_ADDR_CTX0 || waddr == `MBU_ADDR_CTX1)) begin
         m_ctx = ibus_in;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Comparison
   ////////////////////////////////////////////////////////////////////////////

   task automatic report_mismatch(input string name, input logic [7:0] exp_val,
                                  input logic [7:0] act_val);
      errors++;
      $display("ERROR %s expected 0x%h actual 0x%h at %0t ns", name, exp_val, act_val,
               $time);
   endtask

   task automatic compare_outputs();
      resp_t e;
      e = expected_outputs();
      checks++;
      assert (!unwritten_read()) else begin
         errors++;
         $display("Stimulus read a bank that was never written at %0t ns", $time);
      end
      assert (ibus_oe === e.ibus_oe) else report_mismatch("ibus_oe", {7'd0, e.ibus_oe},
                                                          {7'd0, ibus_oe});
      assert (!e.ibus_oe || ibus_out === e.ibus_out) else begin
         report_mismatch("ibus_out", e.ibus_out, ibus_out);
      end
      assert (war === e.war) else report_mismatch("war", {7'd0, e.war}, {7'd0, war});
      assert (!e.war || aext === e.aext) else report_mismatch("aext", e.aext, aext);
   endtask

   // 1 ns before each rising edge
   always begin
      @(negedge clk4);
      #(CLK_PERIOD / 2 - 1);
      if (!arst_n) begin
         m_ctx = '0;
         m_en  = 1'b0;
      end else begin
         compare_outputs();
         update_model();
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////////////////////

   function automatic stim_t idle_stim();
      stim_t s;
      s           = '0;            // raddr and waddr 0 select no unit
      s.ibus_in   = 8'($urandom);
      s.ir        = 3'($urandom);
      s.fpram_rom = switch_val;
      return s;
   endfunction

   task automatic apply(input stim_t s);
      @(posedge clk4);
      #1;
      raddr     = s.raddr;
      waddr     = s.waddr;
      wen       = s.wen;
      ibus_in   = s.ibus_in;
      ir        = s.ir;
      ir_idx    = s.ir_idx;
      fpram_rom = s.fpram_rom;
   endtask

   task automatic write_unit(input logic [4:0] wa, input logic [7:0] din,
                             input logic [2:0] idx);
      stim_t s;
      s         = idle_stim();
      s.waddr   = wa;
      s.wen     = 1'b1;
      s.ibus_in = din;
      s.ir      = idx;
      apply(s);
   endtask

   task automatic read_unit(input logic [4:0] ra, input logic [2:0] idx);
      stim_t s;
      s       = idle_stim();
      s.raddr = ra;
      s.ir    = idx;
      apply(s);
   endtask

   task automatic ar_cycle(input logic [1:0] num, input logic [2:0] idx, input logic use_ir);
      stim_t s;
      s        = idle_stim();
      s.waddr  = {`MBU_WAR_GROUP, num};
      s.wen    = 1'b1;
      s.ir     = idx;
      s.ir_idx = use_ir;
      apply(s);
   endtask

   function automatic logic [7:0] pick_ctx();
      return ctx_list[2'($urandom)];
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Directed phases
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_power_on();
      stim_t s;
      for (int f = 0; f < 2; f++) begin
         switch_val = f[0];
         write_unit(`MBU_ADDR_MBP, 8'h5A ^ 8'(f), 3'd0);    // Stored but hidden
         s       = idle_stim();
         s.waddr = `MBU_ADDR_MBN;                          // wen low, no enable
         apply(s);
         read_unit(`MBU_ADDR_MBN, 3'($urandom));
         read_unit(`MBU_ADDR_MBP, 3'($urandom));
         read_unit(`MBU_ADDR_CTX0, 3'd0);
         read_unit(`MBU_ADDR_CTX1, 3'd0);
         for (int n = 0; n < 4; n++) begin
            ar_cycle(2'(n), 3'($urandom), 1'b0);
         end
         for (int i = 0; i < 8; i++) begin
            ar_cycle(2'($urandom), 3'(i), 1'b1);
         end
      end
   endtask

   // First MBn write here enables the unit
   task automatic fill_contexts();
      for (int c = 0; c < NUM_CTX; c++) begin
         write_unit((c % 2 == 0) ? `MBU_ADDR_CTX0 : `MBU_ADDR_CTX1, ctx_list[c], 3'd0);
         for (int b = 7; b >= 0; b--) begin
            write_unit(`MBU_ADDR_MBN, 8'($urandom), 3'(b));
            if (c == 0 && b == 7) begin
               read_unit(`MBU_ADDR_MBP, 3'($urandom));    // Byte stored while disabled
            end
         end
         for (int b = 0; b < 8; b++) begin
            read_unit(`MBU_ADDR_MBN, 3'(b));
         end
         read_unit(`MBU_ADDR_MBP, 3'($urandom));
      end
   endtask

   task automatic switch_contexts();
      for (int c = NUM_CTX - 1; c >= 0; c--) begin
         write_unit((c % 2 == 0) ? `MBU_ADDR_CTX1 : `MBU_ADDR_CTX0, ctx_list[c], 3'd0);
         read_unit(`MBU_ADDR_CTX0, 3'd0);
         read_unit(`MBU_ADDR_CTX1, 3'd0);
         read_unit(`MBU_ADDR_MBN, 3'($urandom));
         read_unit(`MBU_ADDR_MBP, 3'd0);
         ar_cycle(2'($urandom), 3'($urandom), 1'($urandom));
      end
   endtask

   task automatic sweep_aext();
      stim_t s;
      write_unit(`MBU_ADDR_CTX0, ctx_list[2], 3'd0);
      for (int n = 0; n < 4; n++) begin
         ar_cycle(2'(n), 3'($urandom), 1'b0);
      end
      for (int i = 0; i < 8; i++) begin
         ar_cycle(2'($urandom), 3'(i), 1'b1);
      end
      write_unit(5'h03, 8'($urandom), 3'd0);    // Just below the group
      write_unit(5'h08, 8'($urandom), 3'd0);    // Just above
      s       = idle_stim();
      s.waddr = {`MBU_WAR_GROUP, 2'd1};         // Group address with wen low
      apply(s);
   endtask

   task automatic probe_bus_control();
      stim_t s;
      for (int r = 0; r < 32; r++) begin
         read_unit(5'(r), 3'($urandom));
      end
      s         = idle_stim();
      s.waddr   = `MBU_ADDR_MBN;
      s.ir      = 3'd3;
      apply(s);                                 // No write without wen
      read_unit(`MBU_ADDR_MBN, 3'd3);
      s         = idle_stim();
      s.waddr   = `MBU_ADDR_CTX0;
      s.ibus_in = 8'h5A;
      apply(s);
      read_unit(`MBU_ADDR_CTX0, 3'd0);
      // Same cycle read and write return the old byte
      s         = idle_stim();
      s.raddr   = `MBU_ADDR_MBN;
      s.waddr   = `MBU_ADDR_MBN;
      s.wen     = 1'b1;
      s.ir      = 3'd5;
      apply(s);
      read_unit(`MBU_ADDR_MBN, 3'd5);
      s         = idle_stim();
      s.raddr   = `MBU_ADDR_MBP;
      s.waddr   = `MBU_ADDR_MBP;
      s.wen     = 1'b1;
      apply(s);
      read_unit(`MBU_ADDR_MBP, 3'd0);
      s         = idle_stim();
      s.raddr   = `MBU_ADDR_CTX0;
      s.waddr   = `MBU_ADDR_CTX1;
      s.wen     = 1'b1;
      s.ibus_in = ctx_list[1];
      apply(s);
      read_unit(`MBU_ADDR_CTX0, 3'd0);
   endtask

   task automatic run_random_mix();
      stim_t s;
      for (int i = 0; i < RAND_CYCLES; i++) begin
         switch_val = 1'($urandom);
         s          = idle_stim();
         s.raddr    = 5'($urandom);
         s.waddr    = 5'($urandom);
         s.wen      = 1'($urandom);
         s.ir_idx   = 1'($urandom);
         case ($urandom_range(0, 7))    // Bias towards the MBU units
            0: s.waddr = {`MBU_WAR_GROUP, 2'($urandom)};
            1: s.waddr = `MBU_ADDR_MBN;
            2: s.waddr = `MBU_ADDR_MBP;
            default: ;
         endcase
         if (s.waddr == `MBU_ADDR_CTX0 || s.waddr == `MBU_ADDR_CTX1) begin
            s.ibus_in = pick_ctx();       // Only filled contexts
         end
         apply(s);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Run control
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      seed_val   = $urandom(SEED);
      clk4       = 1'b0;
      arst_n     = 1'b0;
      raddr      = '0;
      waddr      = '0;
      wen        = 1'b0;
      ibus_in    = '0;
      ir         = '0;
      ir_idx     = 1'b0;
      fpram_rom  = 1'b0;
      switch_val = 1'b0;
      m_ctx      = '0;
      m_en       = 1'b0;
      checks     = 0;
      errors     = 0;
      foreach (written[i]) begin
         written[i] = 1'b0;
      end
      repeat (RST_CYCLES) @(posedge clk4);
      #1;
      arst_n = 1'b1;
      check_power_on();
      fill_contexts();
      switch_contexts();
      sweep_aext();
      probe_bus_control();
      run_random_mix();
      apply(idle_stim());
      @(posedge clk4);
      $display("Checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   // Twice the expected run length
   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired before the test sequence finished");
      $display("Checks %0d errors %0d", checks, errors);
      $display("sim failed");
      $finish;
   end

endmodule

// ==== filelist.f ====
+incdir+logic
logic/mbu_pkg.sv
logic/mbu_decoder.sv
logic/mbu_control.sv
logic/mbu_bank_ram.sv
logic/mbu.sv
verification/mbu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the MBU testbench with Verilator
# The result is taken from the pass message in the simulation log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

rm -f "$BUILD_LOG" "$SIM_LOG"

verilator --binary --timing --assert \
   --timescale 1ns/1ps \
   --top-module mbu_tb \
   -f filelist.f \
   --Mdir "$BUILD_DIR" -o mbu_sim > "$BUILD_LOG" 2>&1 \
   && "./$BUILD_DIR/mbu_sim" > "$SIM_LOG" 2>&1 \
   || echo "Build or simulation returned an error, see $BUILD_LOG and $SIM_LOG"

grep -qx "sim passed" "$SIM_LOG" 2>/dev/null \
   && echo "MBU simulation PASSED" \
   || { echo "MBU simulation FAILED"; exit 1; }

exit 0
